//--- memory/bootRom.hex
// boot image, one 16-bit word per line in hex
// line n is rom word n, words 0x000 to 0x00f
1a2b
4000
c0de
0f3c
8001
5aa5
0123
fedc
3c3c
7e81
0000
ffff
9249
6db6
2468
b00f

//--- list.f
common/memPkg.sv
common/memBusIf.sv
source/addrDecode.sv
memory/bootRom.sv
memory/dataRam.sv
peripherals/gpioPort.sv
peripherals/pwmLed.sv
source/readReturn.sv
source/memoryController.sv
bench/memoryControllerTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= memoryControllerTb
OBJ_DIR ?= obj_dir
FILELIST ?= list.f
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/memoryControllerTb.sv
// directed testbench for the memory controller, run as top level memoryControllerTb
`timescale 1ns/1ps

module memoryControllerTb;
	import memPkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int ROM_TEST_CYCLES = 16 * 2 + 8;
	localparam int RAM_TEST_CYCLES = 32 * 3 + 8;
	localparam int GPIO_TEST_CYCLES = 24;
	localparam int PWM_TEST_CYCLES = PWM_PERIOD + 24;
	localparam int HOLD_TEST_CYCLES = 24;
	// generous margin over the summed test lengths
	localparam int TIMEOUT_CYCLES = 6 * (RESET_CYCLES + ROM_TEST_CYCLES + RAM_TEST_CYCLES
		+ GPIO_TEST_CYCLES + PWM_TEST_CYCLES + HOLD_TEST_CYCLES);

	logic CLK;
	logic RSTb;
	logic [ADDR_BITS-1:0] ADDRESS;
	logic [DATA_BITS-1:0] DATA_IN;
	logic [DATA_BITS-1:0] DATA_OUT;
	logic memWR;
	logic memRD;
	logic [PIN_BITS-1:0] PINS;
	logic [GPIO_IN_BITS-1:0] INPUT_PINS;

	integer seed;
	int checkCount;
	int errorCount;
	logic [DATA_BITS-1:0] romModel [16]; // expected boot image
	logic [DATA_BITS-1:0] ramModel [RAM_WORDS];

	memoryController i_dut (
		.CLK(CLK),
		.RSTb(RSTb),
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.DATA_OUT(DATA_OUT),
		.memWR(memWR),
		.memRD(memRD),
		.PINS(PINS),
		.INPUT_PINS(INPUT_PINS)
	);

	always #5 CLK = ~CLK;

	task automatic checkValue(input string testName, input logic [15:0] expected,
		input logic [15:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("FAILED %s: expected 0x%h, actual 0x%h", testName, expected, actual);
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) @(negedge CLK);
	endtask

	// called on a falling edge, returns on the next one
	task automatic writeWord(input logic [15:0] addr, input logic [15:0] data);
		ADDRESS = addr;
		DATA_IN = data;
		memWR = 1'b1;
		@(negedge CLK);
		memWR = 1'b0;
	endtask

	task automatic readWord(input logic [15:0] addr, output logic [15:0] data);
		ADDRESS = addr;
		memRD = 1'b1;
		@(posedge CLK); // read edge
		@(negedge CLK);
		data = DATA_OUT;
		memRD = 1'b0;
	endtask

	task automatic testRomRead();
		logic [15:0] got;
		for (int i = 0; i < 16; i++) begin
			readWord(16'(i), got);
			checkValue($sformatf("rom read %0d", i), romModel[i], got);
		end
	endtask

	task automatic testRamReadback();
		logic [13:0] offs [32];
		logic [31:0] rnd;
		logic [15:0] got;
		for (int i = 0; i < 32; i++) begin
			rnd = $random(seed);
			offs[i] = rnd[13:0];
			ramModel[rnd[13:0]] = rnd[31:16]; // later writes to the same offset win
			writeWord({RAM_BANK, rnd[13:0]}, rnd[31:16]);
		end
		for (int i = 0; i < 32; i++) begin
			readWord({RAM_BANK, offs[i]}, got);
			checkValue($sformatf("ram offset 0x%h", offs[i]), ramModel[offs[i]], got);
		end
		writeWord(16'h0005, ~romModel[5]); // rom is read only
		readWord(16'h0005, got);
		checkValue("rom write ignored", romModel[5], got);
	endtask

	task automatic testGpio();
		logic [31:0] rnd;
		logic [15:0] got;
		writeWord({GPIO_PAGE, GPIO_OUT_REG}, 16'h000a);
		checkValue("gpio pins 0xa", 16'h000a, {12'b0, PINS[3:0]});
		readWord({GPIO_PAGE, GPIO_OUT_REG}, got);
		checkValue("gpio out readback 0xa", 16'h000a, got);
		writeWord({GPIO_PAGE, GPIO_OUT_REG}, 16'hfff5); // only 4 bits are kept
		checkValue("gpio pins 0x5", 16'h0005, {12'b0, PINS[3:0]});
		readWord({GPIO_PAGE, GPIO_OUT_REG}, got);
		checkValue("gpio out readback 0x5", 16'h0005, got);
		rnd = $random(seed);
		INPUT_PINS = rnd[5:0];
		idle(2); // synchroniser depth
		readWord({GPIO_PAGE, GPIO_IN_REG}, got);
		checkValue("gpio input", {10'b0, rnd[5:0]}, got);
		readWord({GPIO_PAGE, 8'h02}, got);
		checkValue("gpio unused offset", 16'h0000, got);
	endtask

	task automatic testPwm();
		logic [7:0] regOff [3];
		int dutyVal [3];
		int highCount [3];
		int expectedHigh;
		logic [15:0] got;
		regOff[0] = PWM_DUTY0_REG;
		regOff[1] = PWM_DUTY1_REG;
		regOff[2] = PWM_DUTY2_REG;
		dutyVal[0] = 0;
		dutyVal[1] = 255;
		dutyVal[2] = 128;
		for (int ch = 0; ch < 3; ch++) begin
			writeWord({PWM_PAGE, regOff[ch]}, 16'(dutyVal[ch]));
			highCount[ch] = 0;
		end
		idle(3); // let the led flops follow the new duties
		repeat (PWM_PERIOD) begin
			@(negedge CLK);
			for (int ch = 0; ch < 3; ch++) begin
				if (PINS[8 + ch]) highCount[ch]++;
			end
		end
		for (int ch = 0; ch < 3; ch++) begin
			// counter values below the duty, at most a whole period
			expectedHigh = (dutyVal[ch] < PWM_PERIOD) ? dutyVal[ch] : PWM_PERIOD;
			checkValue($sformatf("pwm channel %0d high cycles", ch), 16'(expectedHigh),
				16'(highCount[ch]));
			readWord({PWM_PAGE, regOff[ch]}, got);
			checkValue($sformatf("pwm duty %0d readback", ch), 16'(dutyVal[ch]), got);
		end
	endtask

	task automatic testUnmappedHold();
		logic [15:0] got;
		readWord(16'h3000, got);
		checkValue("unmapped 0x3000", 16'h0000, got);
		readWord(16'hffff, got);
		checkValue("unmapped 0xffff", 16'h0000, got);
		readWord(16'h0003, got);
		checkValue("hold source read", romModel[3], got);
		for (int i = 0; i < 6; i++) begin
			ADDRESS = 16'(4 + i); // rom keeps fetching other words, output must not
			@(negedge CLK);
			checkValue($sformatf("hold idle cycle %0d", i), romModel[3], DATA_OUT);
		end
	endtask

	initial begin
		CLK = 1'b0;
		RSTb = 1'b0;
		ADDRESS = '0;
		DATA_IN = '0;
		memWR = 1'b0;
		memRD = 1'b0;
		INPUT_PINS = '0;
		seed = 99910;
		checkCount = 0;
		errorCount = 0;
		$readmemh(ROM_FILE, romModel);
		repeat (RESET_CYCLES) @(negedge CLK);
		RSTb = 1'b1;
		checkValue("reset data out", 16'h0000, DATA_OUT);
		checkValue("reset pins", 16'h0000, {5'b0, PINS});
		testRomRead();
		testRamReadback();
		testGpio();
		testPwm();
		testUnmappedHold();
		idle(2);
		$display("done: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("watchdog timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- source/memoryController.sv
// memory controller top: joins decode stage, memories, peripherals and read return
`timescale 1ns/1ps

module memoryController (
	input logic CLK,
	input logic RSTb,
	input logic [memPkg::ADDR_BITS-1:0] ADDRESS,
	input logic [memPkg::DATA_BITS-1:0] DATA_IN,
	output logic [memPkg::DATA_BITS-1:0] DATA_OUT,
	input logic memWR, // write strobe
	input logic memRD, // read request
	output logic [memPkg::PIN_BITS-1:0] PINS,
	input logic [memPkg::GPIO_IN_BITS-1:0] INPUT_PINS
);

	memBusIf romBus ();
	memBusIf ramBus ();
	memBusIf gpioBus ();
	memBusIf pwmBus ();

	addrDecode i_addrDecode (
		.ADDRESS(ADDRESS),
		.DATA_IN(DATA_IN),
		.memWR(memWR),
		.romBus(romBus.decoder),
		.ramBus(ramBus.decoder),
		.gpioBus(gpioBus.decoder),
		.pwmBus(pwmBus.decoder)
	);

	bootRom i_bootRom (
		.CLK(CLK),
		.bus(romBus.target)
	);

	dataRam i_dataRam (
		.CLK(CLK),
		.bus(ramBus.target)
	);

	gpioPort i_gpioPort (
		.CLK(CLK),
		.RSTb(RSTb),
		.bus(gpioBus.target),
		.pins(PINS[3:0]),
		.pinsIn(INPUT_PINS)
	);

	pwmLed i_pwmLed (
		.CLK(CLK),
		.RSTb(RSTb),
		.bus(pwmBus.target),
		.leds(PINS[10:8])
	);

	assign PINS[7:4] = 4'b0000; // pins of the blocks left out

	readReturn i_readReturn (
		.CLK(CLK),
		.RSTb(RSTb),
		.memRD(memRD),
		.romBus(romBus.sink),
		.ramBus(ramBus.sink),
		.gpioBus(gpioBus.sink),
		.pwmBus(pwmBus.sink),
		.DATA_OUT(DATA_OUT)
	);

endmodule

//--- source/readReturn.sv
// return stage: captures the read selects and peripheral data, then muxes and holds DATA_OUT
`timescale 1ns/1ps

module readReturn (
	input logic CLK,
	input logic RSTb,
	input logic memRD,
	memBusIf.sink romBus,
	memBusIf.sink ramBus,
	memBusIf.sink gpioBus,
	memBusIf.sink pwmBus,
	output logic [memPkg::DATA_BITS-1:0] DATA_OUT
);
	import memPkg::*;

	logic [3:0] selQ; // {pwm, gpio, ram, rom} at the read edge
	logic rdQ; // a read was taken at the last edge
	logic [DATA_BITS-1:0] periphQ;
	logic [DATA_BITS-1:0] holdQ;
	logic [DATA_BITS-1:0] curWord;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			selQ <= '0;
			rdQ <= 1'b0;
			holdQ <= '0;
		end else begin
			rdQ <= memRD;
			if (memRD) begin
				selQ <= {pwmBus.sel, gpioBus.sel, ramBus.sel, romBus.sel};
			end
			if (rdQ) begin
				holdQ <= curWord; // keeps the word once the memories move on
			end
		end
	end

	// peripherals answer combinationally, so capture them here
	always_ff @(posedge CLK) begin
		if (memRD) begin
			periphQ <= gpioBus.sel ? gpioBus.rdata : pwmBus.rdata;
		end
	end

	always_comb begin
		case (selQ)
			4'b0001: curWord = romBus.rdata; // already registered in the rom
			4'b0010: curWord = ramBus.rdata;
			4'b0100, 4'b1000: curWord = periphQ;
			default: curWord = '0; // unmapped
		endcase
	end

	assign DATA_OUT = rdQ ? curWord : holdQ;

	assert property (@(posedge CLK) disable iff (!RSTb) $onehot0(selQ))
		else $error("read return holds more than one select");

endmodule

//--- peripherals/pwmLed.sv
// three-channel PWM LED driver with writable duty registers and one shared counter
`timescale 1ns/1ps

module pwmLed (
	input logic CLK,
	input logic RSTb,
	memBusIf.target bus,
	output logic [memPkg::PWM_CHANNELS-1:0] leds
);
	import memPkg::*;

	logic [PWM_BITS-1:0] duty [PWM_CHANNELS];
	logic [PWM_BITS-1:0] cnt;
	logic [PWM_CHANNELS-1:0] ledQ;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			duty <= '{default: '0};
		end else if (bus.wr) begin
			case (bus.addr.periph.regOff)
				PWM_DUTY0_REG: duty[0] <= bus.wdata[PWM_BITS-1:0];
				PWM_DUTY1_REG: duty[1] <= bus.wdata[PWM_BITS-1:0];
				PWM_DUTY2_REG: duty[2] <= bus.wdata[PWM_BITS-1:0];
				default: ;
			endcase
		end
	end

	// free running, wraps after PWM_PERIOD counts
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cnt <= '0;
		end else if (cnt == PWM_BITS'(PWM_PERIOD - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// duty of 255 stays high over the whole cycle
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			ledQ <= '0;
		end else begin
			for (int i = 0; i < PWM_CHANNELS; i++) begin
				ledQ[i] <= cnt < duty[i];
			end
		end
	end

	always_comb begin
		case (bus.addr.periph.regOff)
			PWM_DUTY0_REG: bus.rdata = {{(DATA_BITS-PWM_BITS){1'b0}}, duty[0]};
			PWM_DUTY1_REG: bus.rdata = {{(DATA_BITS-PWM_BITS){1'b0}}, duty[1]};
			PWM_DUTY2_REG: bus.rdata = {{(DATA_BITS-PWM_BITS){1'b0}}, duty[2]};
			default: bus.rdata = '0;
		endcase
	end

	assign leds = ledQ;

endmodule

//--- peripherals/gpioPort.sv
// GPIO port: writable output latch and a synchronised input register behind the peripheral bus
`timescale 1ns/1ps

module gpioPort (
	input logic CLK,
	input logic RSTb,
	memBusIf.target bus,
	output logic [memPkg::GPIO_OUT_BITS-1:0] pins,
	input logic [memPkg::GPIO_IN_BITS-1:0] pinsIn
);
	import memPkg::*;

	logic [GPIO_OUT_BITS-1:0] outReg;
	logic [GPIO_IN_BITS-1:0] syncA; // first stage, may be metastable
	logic [GPIO_IN_BITS-1:0] syncB;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			outReg <= '0;
		end else if (bus.wr && bus.addr.periph.regOff == GPIO_OUT_REG) begin
			outReg <= bus.wdata[GPIO_OUT_BITS-1:0];
		end
	end

	// two flops, so a pin change reaches reads after two edges
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			syncA <= '0;
			syncB <= '0;
		end else begin
			syncA <= pinsIn;
			syncB <= syncA;
		end
	end

	always_comb begin
		case (bus.addr.periph.regOff)
			GPIO_OUT_REG: bus.rdata = {{(DATA_BITS-GPIO_OUT_BITS){1'b0}}, outReg};
			GPIO_IN_REG: bus.rdata = {{(DATA_BITS-GPIO_IN_BITS){1'b0}}, syncB};
			default: bus.rdata = '0; // unused offsets
		endcase
	end

	assign pins = outReg;

endmodule

//--- memory/dataRam.sv
// single-port data RAM, write at the edge and registered read one cycle later
`timescale 1ns/1ps

module dataRam (
	input logic CLK,
	memBusIf.target bus
);
	import memPkg::*;

	logic [DATA_BITS-1:0] ramMem [RAM_WORDS];
	logic [DATA_BITS-1:0] rdataQ;

	always_ff @(posedge CLK) begin
		if (bus.wr) begin
			ramMem[bus.addr.mem.offset] <= bus.wdata;
		end
	end

	// old word is returned on a read during write
	always_ff @(posedge CLK) begin
		if (bus.sel) begin
			rdataQ <= ramMem[bus.addr.mem.offset];
		end
	end

	assign bus.rdata = rdataQ;

	// decoder must only strobe the region it selected
	assert property (@(posedge CLK) bus.wr |-> bus.sel)
		else $error("ram write strobe without select");

endmodule

//--- memory/bootRom.sv
// boot ROM with synchronous read, filled from the hex image at start of simulation
`timescale 1ns/1ps

module bootRom (
	input logic CLK,
	memBusIf.target bus
);
	import memPkg::*;

	logic [DATA_BITS-1:0] romMem [ROM_WORDS];
	logic [DATA_BITS-1:0] rdataQ;

	initial begin
		$readmemh(ROM_FILE, romMem);
	end

	// read word lands one edge after the address
	always_ff @(posedge CLK) begin
		if (bus.sel) begin
			rdataQ <= romMem[bus.addr.mem.offset[ROM_ADDR_BITS-1:0]];
		end
	end

	assign bus.rdata = rdataQ;

endmodule

//--- source/addrDecode.sv
// decode stage: routes the processor address and write strobe to one of the four target ports
`timescale 1ns/1ps

module addrDecode (
	input logic [memPkg::ADDR_BITS-1:0] ADDRESS,
	input logic [memPkg::DATA_BITS-1:0] DATA_IN,
	input logic memWR,
	memBusIf.decoder romBus,
	memBusIf.decoder ramBus,
	memBusIf.decoder gpioBus,
	memBusIf.decoder pwmBus
);
	import memPkg::*;

	memAddr_u addrView;
	logic romHit;
	logic ramHit;
	logic gpioHit;
	logic pwmHit;

	assign addrView = ADDRESS;

	// top nibble zero, taken from bank plus the upper offset bits
	assign romHit = {addrView.mem.bank, addrView.mem.offset[RAM_ADDR_BITS-1:ROM_ADDR_BITS]}
		== ROM_PREFIX;
	assign ramHit = addrView.mem.bank == RAM_BANK;
	assign gpioHit = addrView.periph.page == GPIO_PAGE;
	assign pwmHit = addrView.periph.page == PWM_PAGE;

	assign romBus.sel = romHit;
	assign ramBus.sel = ramHit;
	assign gpioBus.sel = gpioHit;
	assign pwmBus.sel = pwmHit;

	assign romBus.wr = 1'b0; // rom is read only
	assign ramBus.wr = memWR & ramHit;
	assign gpioBus.wr = memWR & gpioHit;
	assign pwmBus.wr = memWR & pwmHit;

	// every target sees the full address and data word
	assign romBus.addr = addrView;
	assign ramBus.addr = addrView;
	assign gpioBus.addr = addrView;
	assign pwmBus.addr = addrView;

	assign romBus.wdata = DATA_IN;
	assign ramBus.wdata = DATA_IN;
	assign gpioBus.wdata = DATA_IN;
	assign pwmBus.wdata = DATA_IN;

	// regions must never overlap
	always_comb begin
		assert ($isunknown(ADDRESS) || $onehot0({romHit, ramHit, gpioHit, pwmHit}))
			else $error("address %h selects more than one target", ADDRESS);
	end

endmodule

//--- common/memBusIf.sv
// one decoded target port between the address decoder, a target and the read-return stage
`timescale 1ns/1ps

interface memBusIf;
	import memPkg::*;

	logic sel; // address falls in this region
	logic wr; // write strobe, already gated by sel
	memAddr_u addr;
	logic [DATA_BITS-1:0] wdata;
	logic [DATA_BITS-1:0] rdata;

	modport decoder (
		output sel, wr, addr, wdata
	);

	modport target (
		input sel, wr, addr, wdata,
		output rdata
	);

	modport sink (
		input sel, rdata
	);

endinterface

//--- common/memPkg.sv
// shared address map, widths, register offsets and address views for the memory controller
package memPkg;

	// word and address widths
	localparam int DATA_BITS = 16;
	localparam int ADDR_BITS = 16;

	// memory depths and their offset widths
	localparam int ROM_WORDS = 4096;
	localparam int RAM_WORDS = 16384;
	localparam int ROM_ADDR_BITS = $clog2(ROM_WORDS);
	localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

	// peripheral view splits the word into a page and a register offset
	localparam int PAGE_BITS = 8;
	localparam int REG_BITS = ADDR_BITS - PAGE_BITS;
	localparam int BANK_BITS = ADDR_BITS - RAM_ADDR_BITS;

	// region prefixes
	localparam logic [3:0] ROM_PREFIX = 4'h0; // 0x0000 - 0x0fff
	localparam logic [PAGE_BITS-1:0] GPIO_PAGE = 8'h11; // 0x11xx
	localparam logic [PAGE_BITS-1:0] PWM_PAGE = 8'h12; // 0x12xx
	localparam logic [BANK_BITS-1:0] RAM_BANK = 2'b01; // 0x4000 - 0x7fff

	// gpio registers
	localparam logic [REG_BITS-1:0] GPIO_OUT_REG = 8'h00;
	localparam logic [REG_BITS-1:0] GPIO_IN_REG = 8'h01;
	localparam int GPIO_OUT_BITS = 4;
	localparam int GPIO_IN_BITS = 6;

	// pwm registers
	localparam logic [REG_BITS-1:0] PWM_DUTY0_REG = 8'h00;
	localparam logic [REG_BITS-1:0] PWM_DUTY1_REG = 8'h01;
	localparam logic [REG_BITS-1:0] PWM_DUTY2_REG = 8'h02;
	localparam int PWM_BITS = 8;
	localparam int PWM_CHANNELS = 3;
	localparam int PWM_PERIOD = 255; // counter runs 0 .. PWM_PERIOD-1

	// output pin bundle of the top level
	localparam int PIN_BITS = 11;

	localparam string ROM_FILE = "memory/bootRom.hex";

	typedef struct packed {
		logic [BANK_BITS-1:0] bank;
		logic [RAM_ADDR_BITS-1:0] offset;
	} memView_t;

	typedef struct packed {
		logic [PAGE_BITS-1:0] page;
		logic [REG_BITS-1:0] regOff;
	} periphView_t;

	// same address word, seen by the memories or by the peripherals
	typedef union packed {
		memView_t mem;
		periphView_t periph;
	} memAddr_u;

endpackage
